//--- sim.f
hdl/xbar_cfg_pkg.sv
hdl/xbar_bus_pkg.sv
hdl/xbar_arb_ctrl.sv
hdl/xbar_cmd_stage.sv
hdl/xbar_rd_tag_fifo.sv
hdl/xbar_resp_return.sv
hdl/xbar_router.sv
verif/tb_clk_gen.sv
verif/xbar_router_chk.sv
verif/tb_xbar_router.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_xbar_router \
  -f sim.f -Mdir obj_dir || exit 1

out=$(./obj_dir/Vtb_xbar_router)
echo "$out"

echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

//--- verif/tb_xbar_router.sv
`timescale 1ns/100ps

module tb_xbar_router;

  import xbar_cfg_pkg::*;
  import xbar_bus_pkg::*;

  localparam int RR_SLAVE   = 2;
  localparam int N_CMDS     = N_MASTERS * N_SLAVES * 2 + 2 * N_MASTERS;
  localparam int CMD_CYCLES = N_MASTERS * 12;  // Worst wait behind three rivals
  localparam int WD_CYCLES  = (N_CMDS * CMD_CYCLES + 20) * 2;

  logic  clk;
  logic  rst_n;
  logic  m_req   [N_MASTERS];
  addr_t m_addr  [N_MASTERS];
  cmd_t  m_cmd   [N_MASTERS];
  data_t m_wdata [N_MASTERS];
  logic  m_ack   [N_MASTERS];
  logic  m_resp  [N_MASTERS];
  data_t m_rdata [N_MASTERS];
  logic  s_req   [N_SLAVES];
  addr_t s_addr  [N_SLAVES];
  cmd_t  s_cmd   [N_SLAVES];
  data_t s_wdata [N_SLAVES];
  logic  s_ack   [N_SLAVES] = '{default: 1'b0};
  logic  s_resp  [N_SLAVES] = '{default: 1'b0};
  data_t s_rdata [N_SLAVES] = '{default: '0};

  // Slave memory models
  data_t      slv_mem   [N_SLAVES][16];
  int         ack_wait  [N_SLAVES];
  logic       ack_armed [N_SLAVES] = '{default: 1'b0};
  data_t      rsp_data  [N_SLAVES][$];
  int         rsp_due   [N_SLAVES][$];
  int         last_due  [N_SLAVES] = '{default: 0};
  int         cyc = 0;
  logic [7:0] lfsr = 8'd53;

  data_t exp_mem [N_SLAVES][16];
  logic  rd_out  [N_MASTERS] = '{default: 1'b0};  // Read outstanding per master
  data_t rr_log  [$];
  logic  rr_active = 1'b0;
  int    n_checks = 0;
  int    n_errors = 0;
  int    mon_errors = 0;
  int    decode_errors = 0;

  tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

  xbar_router i_xbar_router (
    .clk(clk), .rst_n(rst_n),
    .m_req(m_req), .m_addr(m_addr), .m_cmd(m_cmd), .m_wdata(m_wdata),
    .m_ack(m_ack), .m_resp(m_resp), .m_rdata(m_rdata),
    .s_req(s_req), .s_addr(s_addr), .s_cmd(s_cmd), .s_wdata(s_wdata),
    .s_ack(s_ack), .s_resp(s_resp), .s_rdata(s_rdata)
  );

  // Taps 8,6,5,4, one step per bit
  function automatic int random_bits(input int n);
    int   val;
    logic fb;
    val = 0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
      lfsr = {lfsr[6:0], fb};
      val  = (val << 1) | int'(fb);
    end
    return val;
  endfunction

  function automatic addr_t make_addr(input int s, input int idx);
    return {2'(s), 24'h0, 4'(idx), 2'b00};
  endfunction

  //--------------------------------------------------
  // Slave models
  //--------------------------------------------------
  always @(posedge clk) begin
    int due;
    if (!rst_n) begin
      for (int s = 0; s < N_SLAVES; s++) begin
        for (int i = 0; i < 16; i++) begin
          slv_mem[s][i] = 32'hDEAD_0000 | (s << 4) | i;  // Fill from full address
        end
        s_ack[s]  <= 1'b0;
        s_resp[s] <= 1'b0;
      end
    end else begin
      cyc++;
      for (int s = 0; s < N_SLAVES; s++) begin
        s_ack[s]  <= 1'b0;
        s_resp[s] <= 1'b0;
        if (s_req[s] && !s_ack[s]) begin
          if (!ack_armed[s]) begin
            ack_wait[s]  = random_bits(2);  // Ack after 0 to 3 cycles
            ack_armed[s] = 1'b1;
          end
          if (ack_wait[s] == 0) begin
            s_ack[s]     <= 1'b1;
            ack_armed[s] = 1'b0;
            if (s_addr[s][SEL_LSB +: 2] != 2'(s)) begin
              $display("FAIL address_decode expected %0d actual %0d", s,
                       s_addr[s][SEL_LSB +: 2]);
              decode_errors++;
            end
            if (s_cmd[s] == CMD_WR) begin
              slv_mem[s][s_addr[s][5:2]] = s_wdata[s];
              if (rr_active && (s == RR_SLAVE)) rr_log.push_back(s_wdata[s]);
            end else begin
              due = cyc + 1 + random_bits(2);  // Answer after 1 to 4 cycles
              if (due <= last_due[s]) due = last_due[s] + 1;  // Keep order
              last_due[s] = due;
              rsp_data[s].push_back(slv_mem[s][s_addr[s][5:2]]);
              rsp_due[s].push_back(due);
            end
          end else begin
            ack_wait[s]--;
          end
        end
        if (rsp_due[s].size() > 0 && rsp_due[s][0] <= cyc) begin
          s_resp[s]  <= 1'b1;
          s_rdata[s] <= rsp_data[s].pop_front();
          void'(rsp_due[s].pop_front());
        end
      end
    end
  end

  // Outstanding read per master
  always @(posedge clk) begin
    if (rst_n) begin
      for (int m = 0; m < N_MASTERS; m++) begin
        if (m_resp[m]) begin
          assert (rd_out[m]) else begin
            $display("Master %0d got a read response with no read outstanding", m);
            mon_errors++;
          end
          rd_out[m] = 1'b0;
        end
        if (m_req[m] && m_ack[m] && (m_cmd[m] == CMD_RD)) rd_out[m] = 1'b1;
      end
    end
  end

  //--------------------------------------------------
  // Checks and master tasks
  //--------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    assert (actual == expected) else begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      n_errors++;
    end
  endtask

  task automatic check_quiet();
    for (int m = 0; m < N_MASTERS; m++) begin
      check_value("reset", 32'd0, 32'(m_ack[m]));
      check_value("reset", 32'd0, 32'(m_resp[m]));
    end
    for (int s = 0; s < N_SLAVES; s++) begin
      check_value("reset", 32'd0, 32'(s_req[s]));
    end
  endtask

  task automatic run_cmd(input int m, input addr_t a, input cmd_t c, input data_t d,
                         output data_t rd);
    rd = '0;
    @(posedge clk);
    m_req[m]   <= 1'b1;
    m_addr[m]  <= a;
    m_cmd[m]   <= c;
    m_wdata[m] <= d;
    do @(posedge clk); while (!m_ack[m]);
    m_req[m] <= 1'b0;
    if (c == CMD_WR) begin
      exp_mem[a[31:30]][a[5:2]] = d;
    end else begin
      do @(posedge clk); while (!m_resp[m]);
      rd = m_rdata[m];
    end
  endtask

  task automatic write_read_all(input int m);
    addr_t a;
    data_t d;
    data_t rd;
    for (int s = 0; s < N_SLAVES; s++) begin
      a = make_addr(s, m);
      d = {8'hA5, 8'(m), 8'(s), 8'h5A};
      run_cmd(m, a, CMD_WR, d, rd);
      run_cmd(m, a, CMD_RD, '0, rd);
      check_value("write_read", exp_mem[s][m], rd);
    end
  endtask

  task automatic rr_writes(input int m);
    data_t rd;
    repeat (2) run_cmd(m, make_addr(RR_SLAVE, 8 + m), CMD_WR, 32'(m), rd);
  endtask

  //--------------------------------------------------
  // Test sequence
  //--------------------------------------------------
  initial begin
    int err_start;
    for (int m = 0; m < N_MASTERS; m++) begin
      m_req[m]   = 1'b0;
      m_addr[m]  = '0;
      m_cmd[m]   = CMD_RD;
      m_wdata[m] = '0;
    end

    while (rst_n !== 1'b1) begin
      @(posedge clk);
      check_quiet();
    end
    @(posedge clk);
    check_quiet();
    $display("test reset done, errors %0d", n_errors);

    err_start = n_errors;
    fork
      write_read_all(0);
      write_read_all(1);
      write_read_all(2);
      write_read_all(3);
    join
    $display("test write_read done, errors %0d", n_errors - err_start);

    err_start = n_errors;
    rr_active = 1'b1;
    fork
      rr_writes(0);
      rr_writes(1);
      rr_writes(2);
      rr_writes(3);
    join
    while (rr_log.size() < 2 * N_MASTERS) @(posedge clk);
    rr_active = 1'b0;
    for (int i = 1; i < rr_log.size(); i++) begin
      check_value("round_robin", 32'((rr_log[i-1] + 1) % N_MASTERS), rr_log[i]);
    end
    $display("test round_robin done, errors %0d", n_errors - err_start);

    repeat (10) @(posedge clk);  // Let late responses drain
    $display("test address_decode done, errors %0d", decode_errors);
    $display("tests 4, checks %0d, errors %0d", n_checks,
             n_errors + mon_errors + decode_errors);
    if (n_errors + mon_errors + decode_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, a handshake never completed", WD_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule : tb_xbar_router

//--- verif/xbar_router_chk.sv
`timescale 1ns/100ps

module xbar_router_chk (
  input logic                clk,
  input logic                rst_n,
  input logic                m_req   [xbar_cfg_pkg::N_MASTERS],
  input xbar_bus_pkg::addr_t m_addr  [xbar_cfg_pkg::N_MASTERS],
  input xbar_bus_pkg::cmd_t  m_cmd   [xbar_cfg_pkg::N_MASTERS],
  input xbar_bus_pkg::data_t m_wdata [xbar_cfg_pkg::N_MASTERS],
  input logic                m_ack   [xbar_cfg_pkg::N_MASTERS],
  input logic                m_resp  [xbar_cfg_pkg::N_MASTERS],
  input logic                s_req   [xbar_cfg_pkg::N_SLAVES],
  input xbar_bus_pkg::addr_t s_addr  [xbar_cfg_pkg::N_SLAVES],
  input xbar_bus_pkg::cmd_t  s_cmd   [xbar_cfg_pkg::N_SLAVES],
  input xbar_bus_pkg::data_t s_wdata [xbar_cfg_pkg::N_SLAVES],
  input logic                s_ack   [xbar_cfg_pkg::N_SLAVES],
  input logic                s_resp  [xbar_cfg_pkg::N_SLAVES]
);

  import xbar_cfg_pkg::*;
  import xbar_bus_pkg::*;

  logic       ack_hit  [N_SLAVES];  // A master was acked for this slave
  addr_t      ack_addr [N_SLAVES];
  cmd_t       ack_cmd  [N_SLAVES];
  data_t      ack_data [N_SLAVES];
  logic [2:0] n_s_resp;             // Slave responses this cycle
  logic [2:0] n_m_resp;

  // Acked command per slave by select field
  always_comb begin
    for (int s = 0; s < N_SLAVES; s++) begin
      ack_hit[s]  = 1'b0;
      ack_addr[s] = '0;
      ack_cmd[s]  = CMD_RD;
      ack_data[s] = '0;
      for (int m = 0; m < N_MASTERS; m++) begin
        if (m_ack[m] && (m_addr[m][SEL_LSB +: 2] == slave_id_t'(s))) begin
          ack_hit[s]  = 1'b1;
          ack_addr[s] = m_addr[m];
          ack_cmd[s]  = m_cmd[m];
          ack_data[s] = m_wdata[m];
        end
      end
    end
  end

  always_comb begin
    n_s_resp = '0;
    n_m_resp = '0;
    for (int s = 0; s < N_SLAVES; s++) begin
      n_s_resp = n_s_resp + 3'(s_resp[s]);
    end
    for (int m = 0; m < N_MASTERS; m++) begin
      n_m_resp = n_m_resp + 3'(m_resp[m]);
    end
  end

  //--------------------------------------------------
  // Master side
  //--------------------------------------------------
  for (genvar m = 0; m < N_MASTERS; m++) begin : g_master
    a_m_quiet: assert property (@(posedge clk) !rst_n |-> !m_ack[m] && !m_resp[m])
      else $error("master %0d active during reset", m);
    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n) m_ack[m] |-> m_req[m])
      else $error("m_ack without m_req on master %0d", m);
    for (genvar b = m + 1; b < N_MASTERS; b++) begin : g_pair
      a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
          !(m_ack[m] && m_ack[b] && (m_addr[m][SEL_LSB +: 2] == m_addr[b][SEL_LSB +: 2])))
        else $error("masters %0d and %0d acked for one slave", m, b);
    end
  end

  // Every slave response reaches exactly one master a cycle later
  a_resp_cnt: assert property (@(posedge clk) disable iff (!rst_n)
      n_m_resp == $past(n_s_resp))
    else $error("master responses differ from slave responses one cycle earlier");

  //--------------------------------------------------
  // Slave side
  //--------------------------------------------------
  for (genvar s = 0; s < N_SLAVES; s++) begin : g_slave
    a_s_quiet: assert property (@(posedge clk) !rst_n || $rose(rst_n) |-> !s_req[s])
      else $error("s_req %0d high around reset", s);
    a_sel: assert property (@(posedge clk) disable iff (!rst_n)
        s_req[s] |-> (s_addr[s][SEL_LSB +: 2] == slave_id_t'(s)))
      else $error("command on slave %0d has a foreign select field", s);
    a_load: assert property (@(posedge clk) disable iff (!rst_n)
        ack_hit[s] |=> s_req[s] && (s_addr[s] == $past(ack_addr[s])) &&
        (s_cmd[s] == $past(ack_cmd[s])) && (s_wdata[s] == $past(ack_data[s])))
      else $error("slave %0d command differs from the acked master command", s);
    a_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(s_req[s]) |-> $past(ack_hit[s]))
      else $error("s_req %0d rose without a master ack one cycle earlier", s);
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_req[s] && !s_ack[s] |=> s_req[s] && $stable(s_addr[s]) &&
        $stable(s_cmd[s]) && $stable(s_wdata[s]))
      else $error("slave %0d request changed before s_ack", s);
  end

endmodule : xbar_router_chk

bind xbar_router xbar_router_chk i_router_chk (
  .clk(clk), .rst_n(rst_n), .m_req(m_req), .m_addr(m_addr), .m_cmd(m_cmd),
  .m_wdata(m_wdata), .m_ack(m_ack), .m_resp(m_resp), .s_req(s_req), .s_addr(s_addr),
  .s_cmd(s_cmd), .s_wdata(s_wdata), .s_ack(s_ack), .s_resp(s_resp)
);

//--- verif/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int RST_CYCLES = 2;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;  // Release on a rising edge
  end

endmodule : tb_clk_gen

//--- hdl/xbar_router.sv
`timescale 1ns/100ps

module xbar_router (
  input  logic                clk,
  input  logic                rst_n,
  // Master side
  input  logic                m_req   [xbar_cfg_pkg::N_MASTERS],
  input  xbar_bus_pkg::addr_t m_addr  [xbar_cfg_pkg::N_MASTERS],
  input  xbar_bus_pkg::cmd_t  m_cmd   [xbar_cfg_pkg::N_MASTERS],
  input  xbar_bus_pkg::data_t m_wdata [xbar_cfg_pkg::N_MASTERS],
  output logic                m_ack   [xbar_cfg_pkg::N_MASTERS],
  output logic                m_resp  [xbar_cfg_pkg::N_MASTERS],
  output xbar_bus_pkg::data_t m_rdata [xbar_cfg_pkg::N_MASTERS],
  // Slave side
  output logic                s_req   [xbar_cfg_pkg::N_SLAVES],
  output xbar_bus_pkg::addr_t s_addr  [xbar_cfg_pkg::N_SLAVES],
  output xbar_bus_pkg::cmd_t  s_cmd   [xbar_cfg_pkg::N_SLAVES],
  output xbar_bus_pkg::data_t s_wdata [xbar_cfg_pkg::N_SLAVES],
  input  logic                s_ack   [xbar_cfg_pkg::N_SLAVES],
  input  logic                s_resp  [xbar_cfg_pkg::N_SLAVES],
  input  xbar_bus_pkg::data_t s_rdata [xbar_cfg_pkg::N_SLAVES]
);

  import xbar_cfg_pkg::*;

  //--------------------------------------------------
  // Per-slave control
  //--------------------------------------------------
  logic       capture       [N_SLAVES];
  master_id_t grant_id      [N_SLAVES];
  logic       rd_push       [N_SLAVES];
  logic       tag_full      [N_SLAVES];
  master_id_t head_id       [N_SLAVES];
  logic       tag_pop       [N_SLAVES];

  xbar_arb_ctrl i_arb_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .m_req      (m_req),
    .m_addr     (m_addr),
    .m_cmd      (m_cmd),
    .stage_busy (s_req),  // Stage is busy exactly while it requests
    .tag_full   (tag_full),
    .m_ack      (m_ack),
    .capture    (capture),
    .grant_id   (grant_id),
    .rd_push    (rd_push)
  );

  //--------------------------------------------------
  // Command stage and read tags, one set per slave
  //--------------------------------------------------
  for (genvar s = 0; s < N_SLAVES; s++) begin : g_slave

    xbar_cmd_stage i_cmd_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .capture  (capture[s]),
      .grant_id (grant_id[s]),
      .m_addr   (m_addr),
      .m_cmd    (m_cmd),
      .m_wdata  (m_wdata),
      .s_ack    (s_ack[s]),
      .s_req    (s_req[s]),
      .s_addr   (s_addr[s]),
      .s_cmd    (s_cmd[s]),
      .s_wdata  (s_wdata[s])
    );

    xbar_rd_tag_fifo i_rd_tag_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (rd_push[s]),
      .push_id   (grant_id[s]),
      .pop       (tag_pop[s]),
      .head_id   (head_id[s]),
      .not_empty (),
      .full      (tag_full[s])
    );

  end : g_slave

  // Read data back to the issuing master
  xbar_resp_return i_resp_return (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_resp  (s_resp),
    .s_rdata (s_rdata),
    .head_id (head_id),
    .tag_pop (tag_pop),
    .m_resp  (m_resp),
    .m_rdata (m_rdata)
  );

endmodule : xbar_router

//--- hdl/xbar_resp_return.sv
`timescale 1ns/100ps

module xbar_resp_return (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     s_resp  [xbar_cfg_pkg::N_SLAVES],
  input  xbar_bus_pkg::data_t      s_rdata [xbar_cfg_pkg::N_SLAVES],
  input  xbar_cfg_pkg::master_id_t head_id [xbar_cfg_pkg::N_SLAVES],
  output logic                     tag_pop [xbar_cfg_pkg::N_SLAVES],
  output logic                     m_resp  [xbar_cfg_pkg::N_MASTERS],
  output xbar_bus_pkg::data_t      m_rdata [xbar_cfg_pkg::N_MASTERS]
);

  import xbar_cfg_pkg::*;
  import xbar_bus_pkg::*;

  logic  resp_d  [N_MASTERS];
  data_t rdata_d [N_MASTERS];

  // Each response retires the oldest tag of its slave
  assign tag_pop = s_resp;

  //--------------------------------------------------
  // Route by head tag
  //--------------------------------------------------
  // One read per master in flight, so two slaves never aim at one master
  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      resp_d[m]  = 1'b0;
      rdata_d[m] = '0;
    end
    for (int s = 0; s < N_SLAVES; s++) begin
      if (s_resp[s]) begin
        resp_d[head_id[s]]  = 1'b1;
        rdata_d[head_id[s]] = s_rdata[s];
      end
    end
  end

  //--------------------------------------------------
  // Output registers
  //--------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int m = 0; m < N_MASTERS; m++) begin
        m_resp[m] <= 1'b0;
      end
    end else begin
      m_resp <= resp_d;  // One cycle pulse, one cycle after s_resp
    end
  end

  always_ff @(posedge clk) begin
    for (int m = 0; m < N_MASTERS; m++) begin
      if (resp_d[m]) begin
        m_rdata[m] <= rdata_d[m];
      end
    end
  end

endmodule : xbar_resp_return

//--- hdl/xbar_rd_tag_fifo.sv
`timescale 1ns/100ps

module xbar_rd_tag_fifo (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push,
  input  xbar_cfg_pkg::master_id_t push_id,
  input  logic                     pop,
  output xbar_cfg_pkg::master_id_t head_id,
  output logic                     not_empty,
  output logic                     full
);

  import xbar_cfg_pkg::*;

  master_id_t mem [TAG_DEPTH];  // Issuing master of each pending read
  tag_ptr_t   wr_ptr;
  tag_ptr_t   rd_ptr;
  tag_cnt_t   count;
  logic       do_push;
  logic       do_pop;

  assign full      = (count == tag_cnt_t'(TAG_DEPTH));
  assign not_empty = (count != '0);
  assign head_id   = mem[rd_ptr];  // Oldest read, answered next by the slave

  // Guards against a stray strobe
  assign do_push = push && !full;
  assign do_pop  = pop && not_empty;

  //--------------------------------------------------
  // Pointers and occupancy
  //--------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at TAG_DEPTH
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  // Tag storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_id;
    end
  end

endmodule : xbar_rd_tag_fifo

//--- hdl/xbar_cmd_stage.sv
`timescale 1ns/100ps

module xbar_cmd_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     capture,
  input  xbar_cfg_pkg::master_id_t grant_id,
  input  xbar_bus_pkg::addr_t      m_addr  [xbar_cfg_pkg::N_MASTERS],
  input  xbar_bus_pkg::cmd_t       m_cmd   [xbar_cfg_pkg::N_MASTERS],
  input  xbar_bus_pkg::data_t      m_wdata [xbar_cfg_pkg::N_MASTERS],
  input  logic                     s_ack,
  output logic                     s_req,
  output xbar_bus_pkg::addr_t      s_addr,
  output xbar_bus_pkg::cmd_t       s_cmd,
  output xbar_bus_pkg::data_t      s_wdata
);

  //--------------------------------------------------
  // Request flag
  //--------------------------------------------------
  // Holds one command at a time. The controller only captures while
  // s_req is low, and the slave only acks while s_req is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_req <= 1'b0;
    end else if (capture) begin
      s_req <= 1'b1;  // Rises the cycle after m_ack
    end else if (s_ack) begin
      s_req <= 1'b0;  // Falls the cycle after s_ack
    end
  end

  //--------------------------------------------------
  // Command fields
  //--------------------------------------------------
  // Loaded from the winning master, then steady until the slave acks
  always_ff @(posedge clk) begin
    if (capture) begin
      s_addr  <= m_addr[grant_id];
      s_cmd   <= m_cmd[grant_id];
      s_wdata <= m_wdata[grant_id];
    end
  end

endmodule : xbar_cmd_stage

//--- hdl/xbar_arb_ctrl.sv
`timescale 1ns/100ps

module xbar_arb_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     m_req      [xbar_cfg_pkg::N_MASTERS],
  input  xbar_bus_pkg::addr_t      m_addr     [xbar_cfg_pkg::N_MASTERS],
  input  xbar_bus_pkg::cmd_t       m_cmd      [xbar_cfg_pkg::N_MASTERS],
  input  logic                     stage_busy [xbar_cfg_pkg::N_SLAVES],
  input  logic                     tag_full   [xbar_cfg_pkg::N_SLAVES],
  output logic                     m_ack      [xbar_cfg_pkg::N_MASTERS],
  output logic                     capture    [xbar_cfg_pkg::N_SLAVES],
  output xbar_cfg_pkg::master_id_t grant_id   [xbar_cfg_pkg::N_SLAVES],
  output logic                     rd_push    [xbar_cfg_pkg::N_SLAVES]
);

  import xbar_cfg_pkg::*;
  import xbar_bus_pkg::*;

  slave_id_t  tgt    [N_MASTERS];            // Decoded target per master
  logic       elig   [N_MASTERS][N_SLAVES];  // Master may win this slave now
  master_id_t rr_ptr [N_SLAVES];             // Last granted master per slave

  //--------------------------------------------------
  // Address decode and eligibility
  //--------------------------------------------------
  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      tgt[m] = m_addr[m][SEL_LSB +: $bits(slave_id_t)];
      for (int s = 0; s < N_SLAVES; s++) begin
        // A read waits while that slave has no room for its tag
        elig[m][s] = m_req[m] && (tgt[m] == slave_id_t'(s)) &&
                     !((m_cmd[m] == CMD_RD) && tag_full[s]);
      end
    end
  end

  //--------------------------------------------------
  // Round-robin pick per slave
  //--------------------------------------------------
  always_comb begin
    master_id_t cand;
    logic       found;

    for (int m = 0; m < N_MASTERS; m++) begin
      m_ack[m] = 1'b0;
    end

    for (int s = 0; s < N_SLAVES; s++) begin
      found       = 1'b0;
      grant_id[s] = rr_ptr[s];

      // Search starts just after the last winner, wraps to it last
      for (int k = 1; k <= N_MASTERS; k++) begin
        cand = rr_ptr[s] + master_id_t'(k);
        if (!found && !stage_busy[s] && elig[cand][s]) begin
          found       = 1'b1;
          grant_id[s] = cand;
        end
      end

      capture[s] = found;
      rd_push[s] = found && (m_cmd[grant_id[s]] == CMD_RD);  // Tag goes in with the read

      if (found) begin
        m_ack[grant_id[s]] = 1'b1;  // Combinational ack to the winner
      end
    end
  end

  //--------------------------------------------------
  // Pointer registers
  //--------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < N_SLAVES; s++) begin
        rr_ptr[s] <= master_id_t'(N_MASTERS - 1);  // Master 0 first after reset
      end
    end else begin
      for (int s = 0; s < N_SLAVES; s++) begin
        if (capture[s]) begin
          rr_ptr[s] <= grant_id[s];
        end
      end
    end
  end

endmodule : xbar_arb_ctrl

//--- hdl/xbar_bus_pkg.sv
package xbar_bus_pkg;

  //--------------------------------------------------
  // Bus fields
  //--------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Slave select sits in the top two address bits
  localparam int SEL_LSB = 30;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Command encoding
  typedef logic cmd_t;

  localparam cmd_t CMD_RD = 1'b0;  // Read, answered later with resp
  localparam cmd_t CMD_WR = 1'b1;  // Write, no response

endpackage : xbar_bus_pkg

//--- hdl/xbar_cfg_pkg.sv
package xbar_cfg_pkg;

  //--------------------------------------------------
  // Crossbar size
  //--------------------------------------------------
  localparam int N_MASTERS = 4;  // Master ports
  localparam int N_SLAVES  = 4;  // Slave ports

  // Index of a master port, also used as the read tag
  typedef logic [1:0] master_id_t;

  // Index of a slave port, taken from the address select field
  typedef logic [1:0] slave_id_t;

  //--------------------------------------------------
  // Read tag queue
  //--------------------------------------------------
  // Reads in flight per slave. Each master has at most one read
  // outstanding, so four entries never stall a read for long
  localparam int TAG_DEPTH = 4;

  typedef logic [2:0] tag_cnt_t;  // Occupancy 0..TAG_DEPTH
  typedef logic [1:0] tag_ptr_t;  // Slot index within the queue

endpackage : xbar_cfg_pkg
